//--- rtl/wb_gpr_pkg.sv
// general register word type, register index and write width encodings
`default_nettype none

package wb_gpr_pkg;

    // ------------------------------------------------------------------------
    // register file geometry
    // ------------------------------------------------------------------------
    localparam int GPR_COUNT = 8;

    typedef logic [31:0] gpr_word_t;

    // x86 register numbering as found in modrm fields
    typedef enum logic [2:0] {
        EAX = 3'd0,
        ECX = 3'd1,
        EDX = 3'd2,
        EBX = 3'd3,
        ESP = 3'd4,
        EBP = 3'd5,
        ESI = 3'd6,
        EDI = 3'd7
    } gpr_index_t;

    // which lanes of the destination get replaced
    typedef enum logic [1:0] {
        WIDTH_8LO = 2'd0,
        WIDTH_8HI = 2'd1,
        WIDTH_16  = 2'd2,
        WIDTH_32  = 2'd3
    } wr_width_t;

endpackage

`default_nettype wire

//--- rtl/wb_seg_pkg.sv
// segment index encoding, selector and privilege types, cpu mode encoding
`default_nettype none

package wb_seg_pkg;

    // ------------------------------------------------------------------------
    // segment register geometry
    // ------------------------------------------------------------------------
    localparam int SEG_COUNT = 8;

    typedef logic [15:0] selector_t;
    typedef logic [1:0]  priv_t;

    // segment numbering used by the decoder
    typedef enum logic [2:0] {
        ES   = 3'd0,
        CS   = 3'd1,
        SS   = 3'd2,
        DS   = 3'd3,
        FS   = 3'd4,
        GS   = 3'd5,
        LDTR = 3'd6,
        TR   = 3'd7
    } seg_index_t;

    // operating mode as derived from CR0.PE and EFLAGS.VM
    typedef enum logic [1:0] {
        MODE_REAL      = 2'd0,
        MODE_PROTECTED = 2'd1,
        MODE_V8086     = 2'd2
    } cpu_mode_t;

endpackage

`default_nettype wire

//--- rtl/wb_write_decode.sv
// destination, size and byte lane decode for register writes
`default_nettype none

module wb_write_decode
    import wb_gpr_pkg::*;
(
    input  wire logic       is_8bit,
    input  wire logic       operand_32bit,
    input  wire logic       regrm_word,
    input  wire logic       regrm_dword,
    input  wire logic       dst_is_rm,
    input  wire logic       dst_is_reg,
    input  wire logic       dst_is_implicit,
    input  wire gpr_index_t modrm_reg,
    input  wire gpr_index_t modrm_rm,
    input  wire gpr_index_t implicit_index,
    input  wire logic       write_eax,
    input  wire logic       write_regrm,
    output logic            gpr_wr_en,
    output gpr_index_t      gpr_wr_index,
    output wr_width_t       gpr_wr_width
);

    gpr_index_t dst_index;
    logic       op_32bit;

    // rm beats reg beats implicit with EAX as the fallback
    always_comb begin
        if (dst_is_rm) begin
            dst_index = modrm_rm;
        end else if (dst_is_reg) begin
            dst_index = modrm_reg;
        end else if (dst_is_implicit) begin
            dst_index = implicit_index;
        end else begin
            dst_index = EAX;
        end
    end

    assign gpr_wr_en = write_eax ||
                       (write_regrm && (dst_is_rm || dst_is_reg || dst_is_implicit));

    // word override wins over dword override
    assign op_32bit = regrm_word  ? 1'b0 :
                      regrm_dword ? 1'b1 :
                                    operand_32bit;

    // byte codes 4..7 are AH, CH, DH, BH in registers 0..3
    always_comb begin
        gpr_wr_index = dst_index;
        if (is_8bit) begin
            gpr_wr_index = gpr_index_t'({1'b0, dst_index[1:0]});
            gpr_wr_width = dst_index[2] ? WIDTH_8HI : WIDTH_8LO;
        end else begin
            gpr_wr_width = op_32bit ? WIDTH_32 : WIDTH_16;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wb_gpr_file.sv
// eight general registers with lane merge and esp restore
`default_nettype none

module wb_gpr_file
    import wb_gpr_pkg::*;
#(
    parameter gpr_word_t STARTUP_ESP = '0
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       gpr_wr_en,
    input  wire gpr_index_t gpr_wr_index,
    input  wire wr_width_t  gpr_wr_width,
    input  wire gpr_word_t  result,
    input  wire logic       esp_restore,
    input  wire gpr_word_t  esp_prev,
    output gpr_word_t       gpr [GPR_COUNT]
);

    // ------------------------------------------------------------------------
    // lane merge
    // ------------------------------------------------------------------------

    // high byte lane takes the low byte of the result
    function automatic gpr_word_t merge_lane(
        input gpr_word_t old_value,
        input gpr_word_t new_value,
        input wr_width_t width
    );
        gpr_word_t merged;
        merged = old_value;
        case (width)
            WIDTH_8LO: merged[7:0]  = new_value[7:0];
            WIDTH_8HI: merged[15:8] = new_value[7:0];
            WIDTH_16:  merged[15:0] = new_value[15:0];
            default:   merged       = new_value;
        endcase
        return merged;
    endfunction

    gpr_word_t wr_value;

    assign wr_value = merge_lane(gpr[gpr_wr_index], result, gpr_wr_width);

    // ------------------------------------------------------------------------
    // register array
    // ------------------------------------------------------------------------

    // a normal write always beats the exception restore of esp
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < GPR_COUNT; i++) begin
                gpr[i] <= '0;
            end
            gpr[ESP] <= STARTUP_ESP;
        end else if (gpr_wr_en) begin
            gpr[gpr_wr_index] <= wr_value;
        end else if (esp_restore) begin
            gpr[ESP] <= esp_prev;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wb_seg_file.sv
// segment selectors and requested privilege levels
`default_nettype none

module wb_seg_file
    import wb_seg_pkg::*;
#(
    parameter selector_t STARTUP_CS = 16'hF000
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire seg_index_t seg_index,
    input  wire selector_t  seg_sel,
    input  wire logic       write_seg_sel,
    input  wire priv_t      seg_rpl,
    input  wire logic       write_seg_rpl,
    output selector_t       sel [SEG_COUNT],
    output priv_t           rpl [SEG_COUNT],
    output priv_t           cs_rpl
);

    // ------------------------------------------------------------------------
    // selectors
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SEG_COUNT; i++) begin
                sel[i] <= '0;
            end
            sel[CS] <= STARTUP_CS;
        end else if (write_seg_sel) begin
            sel[seg_index] <= seg_sel;
        end
    end

    // ------------------------------------------------------------------------
    // privilege levels
    // ------------------------------------------------------------------------

    // own strobe so rpl can change without a selector load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SEG_COUNT; i++) begin
                rpl[i] <= '0;
            end
        end else if (write_seg_rpl) begin
            rpl[seg_index] <= seg_rpl;
        end
    end

    assign cs_rpl = rpl[CS];

endmodule

`default_nettype wire

//--- rtl/wb_mode_result.sv
// pe, vm and iopl registers with cpl, mode flags and io check level
`default_nettype none

module wb_mode_result
    import wb_seg_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  cr0_pe_in,
    input  wire logic  vmflag_in,
    input  wire priv_t iopl_in,
    input  wire priv_t cs_rpl,
    output priv_t      cpl,
    output logic       real_mode,
    output logic       protected_mode,
    output logic       v8086_mode,
    output logic       io_allow_check_needed
);

    logic      cr0_pe;
    logic      vmflag;
    priv_t     iopl;
    cpu_mode_t mode;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cr0_pe <= 1'b0;
            vmflag <= 1'b0;
            iopl   <= '0;
        end else begin
            cr0_pe <= cr0_pe_in;
            vmflag <= vmflag_in;
            iopl   <= iopl_in;
        end
    end

    // vm only counts once protection is enabled
    always_comb begin
        if (!cr0_pe) begin
            mode = MODE_REAL;
        end else if (vmflag) begin
            mode = MODE_V8086;
        end else begin
            mode = MODE_PROTECTED;
        end
    end

    assign cpl            = cs_rpl;
    assign real_mode      = (mode == MODE_REAL);
    assign protected_mode = (mode == MODE_PROTECTED);
    assign v8086_mode     = (mode == MODE_V8086);

    // in/out needs the tss bitmap when v8086 or cpl above iopl
    assign io_allow_check_needed = cr0_pe && (vmflag || (cpl > iopl));

endmodule

`default_nettype wire

//--- rtl/write_back.sv
// top level of the register write-back stage
`default_nettype none

module write_back
    import wb_gpr_pkg::*;
    import wb_seg_pkg::*;
#(
    parameter gpr_word_t STARTUP_ESP = '0,
    parameter selector_t STARTUP_CS  = 16'hF000
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    // general register write
    input  wire logic       is_8bit,
    input  wire logic       operand_32bit,
    input  wire logic       regrm_word,
    input  wire logic       regrm_dword,
    input  wire logic       dst_is_rm,
    input  wire logic       dst_is_reg,
    input  wire logic       dst_is_implicit,
    input  wire gpr_index_t modrm_reg,
    input  wire gpr_index_t modrm_rm,
    input  wire gpr_index_t implicit_index,
    input  wire logic       write_eax,
    input  wire logic       write_regrm,
    input  wire gpr_word_t  result,
    input  wire logic       esp_restore,
    input  wire gpr_word_t  esp_prev,
    // segment write
    input  wire seg_index_t seg_index,
    input  wire selector_t  seg_sel,
    input  wire logic       write_seg_sel,
    input  wire priv_t      seg_rpl,
    input  wire logic       write_seg_rpl,
    // mode levels
    input  wire logic       cr0_pe_in,
    input  wire logic       vmflag_in,
    input  wire priv_t      iopl_in,
    output gpr_word_t       gpr [GPR_COUNT],
    output selector_t       sel [SEG_COUNT],
    output priv_t           rpl [SEG_COUNT],
    output priv_t           cpl,
    output logic            real_mode,
    output logic            protected_mode,
    output logic            v8086_mode,
    output logic            io_allow_check_needed
);

    logic       gpr_wr_en;
    gpr_index_t gpr_wr_index;
    wr_width_t  gpr_wr_width;
    priv_t      cs_rpl;

    wb_write_decode decode_i (
        .is_8bit(is_8bit), .operand_32bit(operand_32bit),
        .regrm_word(regrm_word), .regrm_dword(regrm_dword),
        .dst_is_rm(dst_is_rm), .dst_is_reg(dst_is_reg), .dst_is_implicit(dst_is_implicit),
        .modrm_reg(modrm_reg), .modrm_rm(modrm_rm), .implicit_index(implicit_index),
        .write_eax(write_eax), .write_regrm(write_regrm),
        .gpr_wr_en(gpr_wr_en), .gpr_wr_index(gpr_wr_index), .gpr_wr_width(gpr_wr_width)
    );

    wb_gpr_file #(.STARTUP_ESP(STARTUP_ESP)) gpr_file_i (
        .clk(clk), .rst_n(rst_n),
        .gpr_wr_en(gpr_wr_en), .gpr_wr_index(gpr_wr_index), .gpr_wr_width(gpr_wr_width),
        .result(result), .esp_restore(esp_restore), .esp_prev(esp_prev),
        .gpr(gpr)
    );

    wb_seg_file #(.STARTUP_CS(STARTUP_CS)) seg_file_i (
        .clk(clk), .rst_n(rst_n),
        .seg_index(seg_index), .seg_sel(seg_sel), .write_seg_sel(write_seg_sel),
        .seg_rpl(seg_rpl), .write_seg_rpl(write_seg_rpl),
        .sel(sel), .rpl(rpl), .cs_rpl(cs_rpl)
    );

    wb_mode_result mode_result_i (
        .clk(clk), .rst_n(rst_n),
        .cr0_pe_in(cr0_pe_in), .vmflag_in(vmflag_in), .iopl_in(iopl_in), .cs_rpl(cs_rpl),
        .cpl(cpl), .real_mode(real_mode), .protected_mode(protected_mode),
        .v8086_mode(v8086_mode), .io_allow_check_needed(io_allow_check_needed)
    );

endmodule

`default_nettype wire

//--- verif/write_back_checker.sv
// register model, reference function and output comparison
`default_nettype none

module write_back_checker
    import wb_gpr_pkg::*;
    import wb_seg_pkg::*;
#(
    parameter gpr_word_t STARTUP_ESP = '0,
    parameter selector_t STARTUP_CS  = 16'hF000
) (
    input  wire logic       clk, rst_n, is_8bit, operand_32bit, regrm_word, regrm_dword,
    input  wire logic       dst_is_rm, dst_is_reg, dst_is_implicit, write_eax, write_regrm,
    input  wire gpr_index_t modrm_reg, modrm_rm, implicit_index,
    input  wire gpr_word_t  result, esp_prev,
    input  wire logic       esp_restore, write_seg_sel, write_seg_rpl, cr0_pe_in, vmflag_in,
    input  wire seg_index_t seg_index,
    input  wire selector_t  seg_sel,
    input  wire priv_t      seg_rpl, iopl_in, cpl,
    input  wire gpr_word_t  gpr [GPR_COUNT],
    input  wire selector_t  sel [SEG_COUNT],
    input  wire priv_t      rpl [SEG_COUNT],
    input  wire logic       real_mode, protected_mode, v8086_mode, io_allow_check_needed,
    output int              error_count,
    output int              check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    gpr_word_t m_gpr [GPR_COUNT];
    selector_t m_sel [SEG_COUNT];
    priv_t     m_rpl [SEG_COUNT];
    logic      m_pe, m_vm, primed = 1'b0;
    priv_t     m_iopl;
    cpu_mode_t m_mode;

    // next value of register r from the decode and lane rules
    function automatic gpr_word_t expected_gpr(input logic [2:0] r, input gpr_word_t old);
        logic [2:0] dst;
        logic [2:0] target;
        logic       en;
        gpr_word_t  mask;
        gpr_word_t  data;
        dst = dst_is_rm ? modrm_rm : dst_is_reg ? modrm_reg :
              dst_is_implicit ? implicit_index : 3'd0;
        en = write_eax | (write_regrm & (dst_is_rm | dst_is_reg | dst_is_implicit));
        data = result;
        if (is_8bit && dst[2]) begin
            mask = 32'h0000_FF00;
            data = {16'h0, result[7:0], 8'h0};
        end else if (is_8bit) begin
            mask = 32'h0000_00FF;
        end else if (!regrm_word && (regrm_dword || operand_32bit)) begin
            mask = 32'hFFFF_FFFF;
        end else begin
            mask = 32'h0000_FFFF;
        end
        target = is_8bit ? {1'b0, dst[1:0]} : dst;
        if (en && target == r) return (old & ~mask) | (data & mask);
        if (!en && esp_restore && r == 3'd4) return esp_prev;
        return old;
    endfunction

    // mode from the registered pe and vm levels
    function automatic cpu_mode_t expected_mode(input logic pe, input logic vm);
        if (!pe) return MODE_REAL;
        if (vm) return MODE_V8086;
        return MODE_PROTECTED;
    endfunction

    task automatic check_value(input string name, input int idx, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            $display("CHECK FAILED %s[%0d] expected %h actual %h", name, idx, exp_v, act_v);
        end
    endtask

    // compare the state of the last edge and then advance the model
    always @(posedge clk) begin
        if (!primed) begin
            error_count = 0;
            check_count = 0;
        end else begin
            m_mode = expected_mode(m_pe, m_vm);
            for (int i = 0; i < 8; i++) begin
                check_value("gpr", i, m_gpr[i], gpr[i]);
                check_value("sel", i, 32'(m_sel[i]), 32'(sel[i]));
                check_value("rpl", i, 32'(m_rpl[i]), 32'(rpl[i]));
            end
            check_value("cpl", 0, 32'(m_rpl[1]), 32'(cpl));
            check_value("real_mode", 0, 32'(m_mode == MODE_REAL), 32'(real_mode));
            check_value("protected_mode", 0, 32'(m_mode == MODE_PROTECTED),
                        32'(protected_mode));
            check_value("v8086_mode", 0, 32'(m_mode == MODE_V8086), 32'(v8086_mode));
            check_value("io_allow_check_needed", 0,
                        32'(m_pe && (m_vm || m_rpl[1] > m_iopl)), 32'(io_allow_check_needed));
        end
        if (!rst_n) begin
            primed = 1'b1;
            for (int i = 0; i < 8; i++) begin
                m_gpr[i] = (i == 4) ? STARTUP_ESP : '0;
                m_sel[i] = (i == 1) ? STARTUP_CS : '0;
                m_rpl[i] = '0;
            end
            {m_pe, m_vm, m_iopl} = '0;
        end else if (primed) begin
            for (int i = 0; i < 8; i++) begin
                m_gpr[i] = expected_gpr(3'(i), m_gpr[i]);
            end
            if (write_seg_sel) m_sel[seg_index] = seg_sel;
            if (write_seg_rpl) m_rpl[seg_index] = seg_rpl;
            {m_pe, m_vm, m_iopl} = {cr0_pe_in, vmflag_in, iopl_in};
        end
    end

endmodule

`default_nettype wire

//--- verif/write_back_tb.sv
// clock, reset, directed and lfsr stimulus, dut and checker hookup
`default_nettype none

module write_back_tb
    import wb_gpr_pkg::*;
    import wb_seg_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // directed phase plus the closing wait
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 33;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int MARGIN_CYCLES   = 51;
    localparam int MAX_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES +
                                     MARGIN_CYCLES;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       is_8bit, operand_32bit, regrm_word, regrm_dword;
    logic       dst_is_rm, dst_is_reg, dst_is_implicit, write_eax, write_regrm;
    gpr_index_t modrm_reg, modrm_rm, implicit_index;
    gpr_word_t  result, esp_prev;
    logic       esp_restore, write_seg_sel, write_seg_rpl, cr0_pe_in, vmflag_in;
    seg_index_t seg_index;
    selector_t  seg_sel;
    priv_t      seg_rpl, iopl_in, cpl;
    gpr_word_t  gpr [GPR_COUNT];
    selector_t  sel [SEG_COUNT];
    priv_t      rpl [SEG_COUNT];
    logic       real_mode, protected_mode, v8086_mode, io_allow_check_needed;
    int         error_count, check_count;
    int         cycle_count = 0;
    logic [15:0] lfsr_state = 16'd64173;
    logic [31:0] ctl, segr, moder, rnd_result, rnd_prev;

    always #50 clk = ~clk;

    write_back dut_i (.*);

    write_back_checker #(.STARTUP_ESP('0), .STARTUP_CS(16'hF000)) checker_i (.*);

    // taps 16, 14, 13, 11
    function automatic logic [31:0] next_random(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic clear_strobes();
        {is_8bit, regrm_word, regrm_dword, write_eax, write_regrm} <= '0;
        {dst_is_rm, dst_is_reg, dst_is_implicit, esp_restore} <= '0;
        {write_seg_sel, write_seg_rpl} <= '0;
    endtask

    // dst_sel bits are {implicit, reg, rm}; unused index fields get decoys
    task automatic gpr_write(input logic [2:0] dst_sel, input gpr_index_t idx,
                             input logic is8, input logic [1:0] size_ovr,
                             input logic op32, input gpr_word_t value);
        @(posedge clk);
        clear_strobes();
        {dst_is_implicit, dst_is_reg, dst_is_rm} <= dst_sel;
        modrm_rm       <= dst_sel[0] ? idx : gpr_index_t'(idx ^ 3'd1);
        modrm_reg      <= dst_sel[1] ? idx : gpr_index_t'(idx ^ 3'd2);
        implicit_index <= dst_sel[2] ? idx : gpr_index_t'(idx ^ 3'd3);
        {regrm_dword, regrm_word} <= size_ovr;
        is_8bit <= is8;
        operand_32bit <= op32;
        write_regrm <= 1'b1;
        result <= value;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("errors: %0d in %0d checks", error_count, check_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clear_strobes();
        {operand_32bit, cr0_pe_in, vmflag_in} <= '0;
        modrm_reg      <= EAX;
        modrm_rm       <= EAX;
        implicit_index <= EAX;
        {result, esp_prev, seg_sel, seg_rpl, iopl_in} <= '0;
        seg_index <= ES;
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // ------------------------------------------------------------------------
        // directed phase
        // ------------------------------------------------------------------------
        for (int i = 0; i < 8; i++) begin
            gpr_write(3'b001, gpr_index_t'(3'(i)), 1'b0, 2'b10, 1'b0,
                      32'(32'h1111_1111 * (i + 1)));
        end
        gpr_write(3'b010, ECX, 1'b0, 2'b01, 1'b1, 32'hABCD_5678);
        gpr_write(3'b100, EDX, 1'b0, 2'b00, 1'b0, 32'h0000_BEEF);
        gpr_write(3'b011, EBX, 1'b0, 2'b11, 1'b0, 32'h7777_1234);
        gpr_write(3'b110, ESI, 1'b0, 2'b00, 1'b1, 32'h0BAD_F00D);
        for (int i = 0; i < 8; i++) begin
            gpr_write(3'b001, gpr_index_t'(3'(i)), 1'b1, 2'b00, 1'b1, 32'(32'hC35A + i));
        end
        @(posedge clk);
        clear_strobes();
        write_eax <= 1'b1;
        result <= 32'hCAFE_0001;
        @(posedge clk);
        clear_strobes();
        write_regrm <= 1'b1;
        result <= 32'hDEAD_0002;
        @(posedge clk);
        clear_strobes();
        esp_restore <= 1'b1;
        esp_prev <= 32'h0000_7FF0;
        // restore and a write in the same cycle
        @(posedge clk);
        write_eax <= 1'b1;
        esp_prev <= 32'h0000_6FE0;
        @(posedge clk);
        clear_strobes();
        seg_index <= CS;
        seg_sel <= 16'h0008;
        seg_rpl <= 2'd3;
        write_seg_sel <= 1'b1;
        @(posedge clk);
        clear_strobes();
        seg_sel <= 16'h0010;
        write_seg_rpl <= 1'b1;
        cr0_pe_in <= 1'b1;
        @(posedge clk);
        clear_strobes();
        seg_index <= DS;
        seg_rpl <= 2'd1;
        write_seg_sel <= 1'b1;
        iopl_in <= 2'd3;
        @(posedge clk);
        clear_strobes();
        vmflag_in <= 1'b1;
        repeat (2) @(posedge clk);
        cr0_pe_in <= 1'b0;
        // ------------------------------------------------------------------------
        // random phase
        // ------------------------------------------------------------------------
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            ctl        = next_random(19);
            segr       = next_random(23);
            moder      = next_random(4);
            rnd_result = next_random(32);
            rnd_prev   = next_random(32);
            @(posedge clk);
            {is_8bit, operand_32bit, regrm_word, regrm_dword} <= ctl[3:0];
            {dst_is_rm, dst_is_reg, dst_is_implicit} <= ctl[6:4];
            modrm_reg      <= gpr_index_t'(ctl[9:7]);
            modrm_rm       <= gpr_index_t'(ctl[12:10]);
            implicit_index <= gpr_index_t'(ctl[15:13]);
            {write_eax, write_regrm, esp_restore} <= ctl[18:16];
            seg_index <= seg_index_t'(segr[2:0]);
            seg_sel   <= segr[18:3];
            {write_seg_sel, write_seg_rpl} <= segr[20:19];
            seg_rpl   <= segr[22:21];
            {cr0_pe_in, vmflag_in} <= moder[1:0];
            iopl_in   <= moder[3:2];
            result    <= rnd_result;
            esp_prev  <= rnd_prev;
        end
        repeat (3) @(posedge clk);
        $display("errors: %0d in %0d checks", error_count, check_count);
        if (error_count == 0 && check_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- write_back.f
rtl/wb_gpr_pkg.sv
rtl/wb_seg_pkg.sv
rtl/wb_write_decode.sv
rtl/wb_gpr_file.sv
rtl/wb_seg_file.sv
rtl/wb_mode_result.sv
rtl/write_back.sv
verif/write_back_checker.sv
verif/write_back_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := write_back_tb
FILELIST := write_back.f
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
